// File: stimulusInput.txt
# columns: charX charY creditMode, one frame per line, decimal
# creditMode 0 returns a credit after each output, 1 returns credits at random
100 50 0
300 200 1
10 300 0
560 120 1
0 0 1
260 420 0

// File: list.f
+incdir+.
pixelPkg.sv
spritePkg.sv
rasterScanner.sv
pixelFifo.sv
partRenderer.sv
layerCompositor.sv
spriteTop.sv
spriteFlow_properties.sv
spriteTb.sv

// File: run.sh
#!/bin/sh
# build and run the sprite compositor testbench with Verilator.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module spriteTb -f list.f -o simSprite
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simSprite > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

// File: spriteTb.sv
`timescale 1ns/1ps
`include "sprite_defs.svh"

module spriteTb;

  localparam int FRAME_PIX  = `SCREEN_W * `SCREEN_H;
  localparam int MAX_FRAMES = 16;

  logic             clk = 1'b0;
  logic             rstN;
  logic             run;
  pixelPkg::coordXT charX;
  pixelPkg::coordYT charY;
  logic             sinkCredit;
  logic             outValid;
  pixelPkg::rgbT    outRgb;
  logic             frameDone;

  int     frameX [MAX_FRAMES];
  int     frameY [MAX_FRAMES];
  int     frameMode [MAX_FRAMES];
  int     numFrames = 0;
  int     creditMode, owed, doneSeen;
  integer seed;

  spriteTop DUT (
    .clk       (clk),
    .rstN      (rstN),
    .run       (run),
    .charX     (charX),
    .charY     (charY),
    .sinkCredit(sinkCredit),
    .outValid  (outValid),
    .outRgb    (outRgb),
    .frameDone (frameDone)
  );

  bind spriteTop spriteFlowProperties uFlowProps (
    .clk       (clk),
    .rstN      (rstN),
    .pushValid (pushValid),
    .popCredit (popCredit),
    .popReq    (popReq),
    .fifoValid (fifoValid),
    .outValid  (outValid),
    .sinkCredit(sinkCredit),
    .frameDone (frameDone)
  );

  always #5 clk = ~clk;

  task automatic stopWithFailure();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic checkRgb(input string name, input pixelPkg::rgbT expected,
                          input pixelPkg::rgbT actual);
    if (expected !== actual) begin
      $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
      stopWithFailure();
    end
  endtask

  task automatic checkCount(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("Fail time=%0t signal=%s expected=%0d actual=%0d", $time, name, expected, actual);
      stopWithFailure();
    end
  endtask

  // colour from the part table where a higher part id is drawn over a lower one.
  function automatic pixelPkg::rgbT modelColor(input int x, input int y, input int bx,
                                               input int by);
    spritePkg::partRectT r;
    pixelPkg::rgbT       c;
    int                  p, rx, ry;
    c = '0;
    for (p = 0; p < spritePkg::NUM_PARTS; p++) begin
      r  = spritePkg::PART_TABLE[p];
      rx = x - bx - int'($signed(r.offX));
      ry = y - by - int'($signed(r.offY));
      if (rx >= 0 && rx < int'(r.width) && ry >= 0 && ry < int'(r.height)) c = r.color;
    end
    return c;
  endfunction

  // pixels of a rectangle that fall on the screen.
  function automatic int visibleArea(input int x0, input int y0, input int w, input int h);
    int cols, rows;
    cols = (x0 + w > `SCREEN_W ? `SCREEN_W : x0 + w) - (x0 < 0 ? 0 : x0);
    rows = (y0 + h > `SCREEN_H ? `SCREEN_H : y0 + h) - (y0 < 0 ? 0 : y0);
    return (cols > 0 && rows > 0) ? cols * rows : 0;
  endfunction

  task automatic readStimulus();
    int    fd, got, n, xv, yv, mv;
    string line;
    n  = 0;
    fd = $fopen("stimulusInput.txt", "r");
    if (fd == 0) begin
      $display("cannot open stimulusInput.txt");
      stopWithFailure();
    end else begin
      while (!$feof(fd) && n < MAX_FRAMES) begin
        got = $fgets(line, fd);
        if (got > 0 && line[0] != "#" && $sscanf(line, "%d %d %d", xv, yv, mv) == 3) begin
          frameX[n]    = xv;
          frameY[n]    = yv;
          frameMode[n] = mv;
          n++;
        end
      end
      $fclose(fd);
      if (n == 0) begin
        $display("stimulusInput.txt holds no frame lines");
        stopWithFailure();
      end else begin
        numFrames = n;
      end
    end
  endtask

  // one sink clock with outputs sampled and inputs driven on the falling edge.
  task automatic stepCycle(output logic gotPix, output pixelPkg::rgbT pix);
    logic credit;
    @(negedge clk);
    gotPix = outValid;
    pix    = outRgb;
    if (frameDone) doneSeen++;
    if (outValid) owed++;
    if (creditMode == 0) credit = (owed > 0);
    else credit = (owed > 0) && (($random(seed) & 1) != 0);
    if (credit) owed--;
    sinkCredit = credit;
  endtask

  task automatic runFrame(input int f);
    int            bx, by, n, x, y, armPix, bandPix;
    logic          gotPix;
    pixelPkg::rgbT pix, armRgb, bodyRgb;
    bx         = frameX[f];
    by         = frameY[f];
    n          = 0;
    armPix     = 0;
    bandPix    = 0;
    armRgb     = spritePkg::PART_TABLE[spritePkg::LEFT_ARM].color;
    bodyRgb    = spritePkg::PART_TABLE[spritePkg::BODY].color;
    creditMode = frameMode[f];
    while (n < FRAME_PIX) begin
      stepCycle(gotPix, pix);
      if (gotPix) begin
        x = n % `SCREEN_W;
        y = n / `SCREEN_W;
        // the previous frame has ended and this one has not.
        if (n == 0) checkCount("frameDone", f, doneSeen);
        checkRgb($sformatf("outRgb(%0d,%0d) frame %0d", x, y, f), modelColor(x, y, bx, by), pix);
        if (x < bx && pix == armRgb) armPix++;
        if (y - by >= 145 && y - by < 150 && x >= bx && x < bx + 100 && pix == bodyRgb) bandPix++;
        // next position lands mid-frame and may only show from the next frame.
        if (n == FRAME_PIX / 2 && f + 1 < numFrames) begin
          charX = pixelPkg::coordXT'(frameX[f + 1]);
          charY = pixelPkg::coordYT'(frameY[f + 1]);
        end
        if (n == 0 && f == numFrames - 1) run = 1'b0;
        n++;
      end
    end
    checkCount("left arm pixels", visibleArea(bx - 20, by + 80, 20, 50), armPix);
    checkCount("body over feet pixels", visibleArea(bx, by + 145, 100, 5), bandPix);
    checkCount("frameDone", f + 1, doneSeen);
  endtask

  initial begin : mainFlow
    int            extra;
    logic          gotPix;
    pixelPkg::rgbT pix;
    rstN       = 1'b0;
    run        = 1'b0;
    charX      = '0;
    charY      = '0;
    sinkCredit = 1'b0;
    seed       = 88;
    owed       = 0;
    doneSeen   = 0;
    creditMode = 0;
    extra      = 0;
    readStimulus();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstN  = 1'b1;
    charX = pixelPkg::coordXT'(frameX[0]);
    charY = pixelPkg::coordYT'(frameY[0]);
    run   = 1'b1;
    for (int f = 0; f < numFrames; f++) runFrame(f);
    // nothing may follow the last frame.
    repeat (64) begin
      stepCycle(gotPix, pix);
      if (gotPix) extra++;
    end
    checkCount("outValid after last frame", 0, extra);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial begin : watchdog
    wait (numFrames > 0);
    repeat (4 * numFrames * FRAME_PIX) @(posedge clk);
    $display("timeout, %0d frames did not complete in time", numFrames);
    stopWithFailure();
  end

endmodule

// File: spriteFlow_properties.sv
`timescale 1ns/1ps
`include "sprite_defs.svh"

module spriteFlowProperties (
  input logic clk,
  input logic rstN,
  input logic pushValid,
  input logic popCredit,
  input logic popReq,
  input logic fifoValid,
  input logic outValid,
  input logic sinkCredit,
  input logic frameDone
);

  int scanCredits;
  int fifoCount;
  int sinkCredits;

  // shadow counts rebuilt from the handshakes alone.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      scanCredits <= `FIFO_DEPTH;
      fifoCount   <= 0;
      sinkCredits <= `SINK_CREDITS;
    end else begin
      scanCredits <= scanCredits + int'(popCredit) - int'(pushValid);
      fifoCount   <= fifoCount + int'(pushValid) - int'(popReq && fifoValid);
      sinkCredits <= sinkCredits + int'(sinkCredit) - int'(outValid);
    end
  end

  scanCreditHeld: assert property (@(posedge clk) disable iff (!rstN)
    pushValid |-> scanCredits > 0)
    else $error("scanner pushed with no credit left");

  fifoNotFull: assert property (@(posedge clk) disable iff (!rstN)
    pushValid |-> fifoCount < `FIFO_DEPTH)
    else $error("pixel FIFO pushed while full");

  sinkCreditHeld: assert property (@(posedge clk) disable iff (!rstN)
    outValid |-> sinkCredits > 0)
    else $error("outValid without output credit");

  quietInReset: assert property (@(posedge clk)
    !rstN |-> !(pushValid || popReq || popCredit || outValid || frameDone))
    else $error("handshake output high during reset");

endmodule

// File: spriteTop.sv
`timescale 1ns/1ps

module spriteTop (
  input  logic             clk,
  input  logic             rstN,
  input  logic             run,
  input  pixelPkg::coordXT charX,
  input  pixelPkg::coordYT charY,
  input  logic             sinkCredit,
  output logic             outValid,
  output pixelPkg::rgbT    outRgb,
  output logic             frameDone
);

  // scanner to FIFO.
  logic             pushValid;
  pixelPkg::coordXT pushX;
  pixelPkg::coordYT pushY;
  logic             pushFirst;
  logic             popCredit;

  // FIFO to compositor.
  logic             fifoValid;
  pixelPkg::coordXT fifoX;
  pixelPkg::coordYT fifoY;
  logic             fifoFirst;
  logic             popReq;

  rasterScanner uScanner (
    .clk      (clk),
    .rstN     (rstN),
    .run      (run),
    .popCredit(popCredit),
    .pushValid(pushValid),
    .pushX    (pushX),
    .pushY    (pushY),
    .pushFirst(pushFirst),
    .frameDone(frameDone)
  );

  pixelFifo uFifo (
    .clk      (clk),
    .rstN     (rstN),
    .pushValid(pushValid),
    .pushX    (pushX),
    .pushY    (pushY),
    .pushFirst(pushFirst),
    .popReq   (popReq),
    .fifoValid(fifoValid),
    .fifoX    (fifoX),
    .fifoY    (fifoY),
    .fifoFirst(fifoFirst),
    .popCredit(popCredit)
  );

  layerCompositor uCompositor (
    .clk       (clk),
    .rstN      (rstN),
    .fifoValid (fifoValid),
    .fifoX     (fifoX),
    .fifoY     (fifoY),
    .fifoFirst (fifoFirst),
    .charX     (charX),
    .charY     (charY),
    .sinkCredit(sinkCredit),
    .popReq    (popReq),
    .outValid  (outValid),
    .outRgb    (outRgb)
  );

endmodule

// File: layerCompositor.sv
`timescale 1ns/1ps
`include "sprite_defs.svh"

module layerCompositor (
  input  logic             clk,
  input  logic             rstN,
  input  logic             fifoValid,
  input  pixelPkg::coordXT fifoX,
  input  pixelPkg::coordYT fifoY,
  input  logic             fifoFirst,
  input  pixelPkg::coordXT charX,
  input  pixelPkg::coordYT charY,
  input  logic             sinkCredit,
  output logic             popReq,
  output logic             outValid,
  output pixelPkg::rgbT    outRgb
);

  localparam int CRED_W = $clog2(`SINK_CREDITS + 1);

  logic [CRED_W-1:0] outCredits;
  pixelPkg::coordXT  baseX;
  pixelPkg::coordYT  baseY;
  pixelPkg::coordXT  curX;
  pixelPkg::coordYT  curY;
  logic              newFrame;
  logic              hit [spritePkg::NUM_PARTS];
  pixelPkg::rgbT     color [spritePkg::NUM_PARTS];
  pixelPkg::rgbT     pixRgb;

  // the result in flight still holds a credit not yet taken from the count.
  assign popReq   = fifoValid && (outCredits > CRED_W'(outValid));
  assign newFrame = popReq && fifoFirst;

  // first pixel of a frame already sees the new position.
  assign curX = newFrame ? charX : baseX;
  assign curY = newFrame ? charY : baseY;

  for (genvar i = 0; i < spritePkg::NUM_PARTS; i++) begin : genPart
    partRenderer #(
      .PART(spritePkg::partIdT'(i))
    ) uRenderer (
      .pixX (fifoX),
      .pixY (fifoY),
      .baseX(curX),
      .baseY(curY),
      .hit  (hit[i]),
      .color(color[i])
    );
  end

  // later entries have higher priority, black when nothing covers the pixel.
  always_comb begin
    pixRgb = pixelPkg::BLACK;
    for (int i = 0; i < spritePkg::NUM_PARTS; i++) begin
      if (hit[i]) begin
        pixRgb = color[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (newFrame) begin
      baseX <= charX;
      baseY <= charY;
    end
    if (popReq) begin
      outRgb <= pixRgb;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid   <= 1'b0;
      outCredits <= CRED_W'(`SINK_CREDITS);
    end else begin
      outValid   <= popReq;
      outCredits <= outCredits + CRED_W'(sinkCredit) - CRED_W'(outValid);
    end
  end

endmodule

// File: partRenderer.sv
`timescale 1ns/1ps

module partRenderer #(
  parameter spritePkg::partIdT PART = spritePkg::HEAD
) (
  input  pixelPkg::coordXT pixX,
  input  pixelPkg::coordYT pixY,
  input  pixelPkg::coordXT baseX,
  input  pixelPkg::coordYT baseY,
  output logic             hit,
  output pixelPkg::rgbT    color
);

  localparam spritePkg::partRectT RECT = spritePkg::PART_TABLE[PART];

  localparam logic signed [11:0] OFF_X  = 12'(RECT.offX);
  localparam logic signed [10:0] OFF_Y  = 11'(RECT.offY);
  localparam logic signed [11:0] SIZE_X = 12'(RECT.width);
  localparam logic signed [10:0] SIZE_Y = 11'(RECT.height);

  logic signed [11:0] relX;
  logic signed [10:0] relY;

  // signed so that a part may reach left of or above the character.
  assign relX = $signed({2'b00, pixX}) - $signed({2'b00, baseX}) - OFF_X;
  assign relY = $signed({2'b00, pixY}) - $signed({2'b00, baseY}) - OFF_Y;

  assign hit = (relX >= 0) && (relX < SIZE_X) && (relY >= 0) && (relY < SIZE_Y);

  // solid colour per part.
  assign color = RECT.color;

endmodule

// File: pixelFifo.sv
`timescale 1ns/1ps
`include "sprite_defs.svh"

module pixelFifo (
  input  logic             clk,
  input  logic             rstN,
  input  logic             pushValid,
  input  pixelPkg::coordXT pushX,
  input  pixelPkg::coordYT pushY,
  input  logic             pushFirst,
  input  logic             popReq,
  output logic             fifoValid,
  output pixelPkg::coordXT fifoX,
  output pixelPkg::coordYT fifoY,
  output logic             fifoFirst,
  output logic             popCredit
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

  pixelPkg::coordXT memX [`FIFO_DEPTH];
  pixelPkg::coordYT memY [`FIFO_DEPTH];
  logic             memFirst [`FIFO_DEPTH];

  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic             pop;

  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign fifoValid = (count != '0);
  assign pop       = popReq && fifoValid;
  assign fifoX     = memX[rdPtr];
  assign fifoY     = memY[rdPtr];
  assign fifoFirst = memFirst[rdPtr];

  // the scanner's credit keeps pushes away from a full buffer.
  always_ff @(posedge clk) begin
    if (pushValid) begin
      memX[wrPtr]     <= pushX;
      memY[wrPtr]     <= pushY;
      memFirst[wrPtr] <= pushFirst;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      count     <= '0;
      popCredit <= 1'b0;
    end else begin
      if (pushValid) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      count     <= count + CNT_W'(pushValid) - CNT_W'(pop);
      // one credit back to the scanner per freed slot.
      popCredit <= pop;
    end
  end

endmodule

// File: rasterScanner.sv
`timescale 1ns/1ps
`include "sprite_defs.svh"

module rasterScanner (
  input  logic             clk,
  input  logic             rstN,
  input  logic             run,
  input  logic             popCredit,
  output logic             pushValid,
  output pixelPkg::coordXT pushX,
  output pixelPkg::coordYT pushY,
  output logic             pushFirst,
  output logic             frameDone
);

  localparam int CRED_W = $clog2(`FIFO_DEPTH + 1);
  localparam pixelPkg::coordXT LAST_X = pixelPkg::coordXT'(`SCREEN_W - 1);
  localparam pixelPkg::coordYT LAST_Y = pixelPkg::coordYT'(`SCREEN_H - 1);

  spritePkg::scanStateT state;
  pixelPkg::coordXT     colX;
  pixelPkg::coordYT     rowY;
  logic [CRED_W-1:0]    credits;
  logic                 lastPix;

  // a push needs a free FIFO slot, which one credit stands for.
  assign pushValid = (state == spritePkg::SCAN) && (credits != '0);
  assign pushX     = colX;
  assign pushY     = rowY;
  assign pushFirst = (colX == '0) && (rowY == '0);
  assign lastPix   = (colX == LAST_X) && (rowY == LAST_Y);
  assign frameDone = pushValid && lastPix;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      credits <= CRED_W'(`FIFO_DEPTH);
    end else begin
      credits <= credits + CRED_W'(popCredit) - CRED_W'(pushValid);
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= spritePkg::IDLE;
      colX  <= '0;
      rowY  <= '0;
    end else begin
      case (state)
        spritePkg::IDLE: begin
          if (run) begin
            state <= spritePkg::SCAN;
          end
        end
        spritePkg::SCAN: begin
          if (pushValid) begin
            if (lastPix) begin
              colX <= '0;
              rowY <= '0;
              // back-to-back frames while run stays high.
              if (!run) begin
                state <= spritePkg::IDLE;
              end
            end else if (colX == LAST_X) begin
              colX <= '0;
              rowY <= rowY + 1'b1;
            end else begin
              colX <= colX + 1'b1;
            end
          end
        end
        default: begin
          state <= spritePkg::IDLE;
        end
      endcase
    end
  end

endmodule

// File: spritePkg.sv
package spritePkg;

  // value order is the priority order, so a higher value wins.
  typedef enum logic [2:0] {
    FEET,
    BODY,
    LEFT_ARM,
    RIGHT_ARM,
    HEAD
  } partIdT;

  localparam int NUM_PARTS = 5;

  // offsets are taken from the character's top-left corner.
  typedef struct packed {
    logic signed [10:0] offX;
    logic signed [9:0]  offY;
    logic [7:0]         width;
    logic [7:0]         height;
    pixelPkg::rgbT      color;
  } partRectT;

  // packed array indexed by partIdT, listed from HEAD down to FEET.
  localparam partRectT [HEAD:FEET] PART_TABLE = '{
    '{11'sd0,   10'sd0,   8'd100, 8'd90, 24'hF2C48D},
    '{11'sd100, 10'sd80,  8'd20,  8'd50, 24'hD08040},
    '{-11'sd20, 10'sd80,  8'd20,  8'd50, 24'hE09050},
    '{11'sd0,   10'sd90,  8'd100, 8'd60, 24'h2050C0},
    '{11'sd0,   10'sd145, 8'd100, 8'd25, 24'h303030}
  };

  typedef enum logic {
    IDLE,
    SCAN
  } scanStateT;

endpackage

// File: pixelPkg.sv
`include "sprite_defs.svh"

package pixelPkg;

  // column and row numbers of a pixel on screen.
  typedef logic [9:0] coordXT;
  typedef logic [8:0] coordYT;

  // red in the top byte, then green, then blue.
  typedef logic [3*`COLOR_W-1:0] rgbT;

  localparam rgbT BLACK = '0;

endpackage

// File: sprite_defs.svh
`ifndef SPRITE_DEFS_SVH
`define SPRITE_DEFS_SVH

// visible frame size in pixels.
`define SCREEN_W 640
`define SCREEN_H 480

// pixel FIFO entries, also the scanner's starting credit.
`define FIFO_DEPTH 8

// credits the sink grants after reset.
`define SINK_CREDITS 4

// bits per colour channel.
`define COLOR_W 8

`endif
